//--- hps_cfg.f
+incdir+.
hps_cfg_pkg.sv
host_cmd_ctrl.sv
video_window_calc.sv
audio_mix_chan.sv
hps_cfg_top.sv
hps_cfg_properties.sv
tb_clk_gen.sv
tb_hps_cfg.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the HPS configuration testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f hps_cfg.f \
	--top-module tb_hps_cfg -o sim_hps_cfg
./obj_dir/sim_hps_cfg | tee sim.log

if grep -q "^All tests passed!$" sim.log; then
	echo "run_sim: PASS"
else
	echo "run_sim: FAIL"
	exit 1
fi

//--- tb_hps_cfg.sv
// HPS configuration testbench
// Directed tests of the host command port, the display window
// sequencer and the stereo mixer pair

`include "hps_cfg_consts.svh"

module tb_hps_cfg;
	timeunit 1ns;
	timeprecision 1ps;
	import hps_cfg_pkg::*;

	localparam int CLK_NS        = 20;
	localparam int TEST_COUNT    = 6;
	localparam int TEST_BUDGET   = 1600;
	localparam int WATCHDOG_NS   = (TEST_COUNT * TEST_BUDGET + 400) * CLK_NS;
	localparam int ACK_LIMIT     = 16;
	// Register update path plus window settle time
	localparam int WIN_SETTLE    = 3 + 20;
	localparam int AUDIO_LATENCY = 8;

	logic      clk, resetd;
	logic      i_io_en, i_io_clk, o_io_ack;
	io_word_t  i_io_din;
	mix_mode_t i_mix;
	logic      i_is_signed;
	sample_t   i_core_l, i_core_r, i_linux_l, i_linux_r;
	aspect_t   i_arx, i_ary;
	pix_dim_t  o_hmin, o_hmax, o_vmin, o_vmax;
	sample_t   o_audio_l, o_audio_r;

	int        checks, errors;
	io_word_t  cmd_words[$];
	mix_mode_t cur_mode;
	atten_t    cur_att;

	tb_clk_gen u_clk (.clk(clk), .resetd(resetd));

	hps_cfg_top uut (.*);

	////////////////////////////////////////
	// Checking and reporting
	////////////////////////////////////////

	task automatic check_val(input string sig, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("mismatch at %0d ns: %s got %0d expected %0d", $time, sig, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - err_start);
	endtask

	////////////////////////////////////////
	// Host port
	////////////////////////////////////////

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (o_io_ack !== level && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		assert (o_io_ack === level) else begin
			errors++;
			$display("host port gave no acknowledge within %0d cycles", ACK_LIMIT);
		end
	endtask

	task automatic host_write(input io_word_t word);
		i_io_din = word;
		i_io_clk = 1'b1;
		wait_ack(1'b1);
		i_io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	// Command word, then every queued data word
	task automatic send_command(input cmd_code_t code);
		i_io_en = 1'b1;
		host_write({8'h00, code});
		foreach (cmd_words[i]) host_write(cmd_words[i]);
		i_io_en = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic set_volume(input atten_t att);
		cmd_words.delete();
		cmd_words.push_back({11'd0, att});
		send_command(`CMD_VOLUME);
		cur_att = att;
	endtask

	////////////////////////////////////////
	// Window and audio expectations
	////////////////////////////////////////

	task automatic check_window(input int hmin, input int hmax, input int vmin, input int vmax);
		repeat (WIN_SETTLE) @(negedge clk);
		check_val("o_hmin", int'(o_hmin), hmin);
		check_val("o_hmax", int'(o_hmax), hmax);
		check_val("o_vmin", int'(o_vmin), vmin);
		check_val("o_vmax", int'(o_vmax), vmax);
	endtask

	// Centered aspect-correct window
	task automatic check_aspect(input int w, input int h, input int vs, input int ax, input int ay);
		int tw, th, vh;
		tw = ((vs != 0) ? vs : h) * ax / ay;
		th = w * ay / ax;
		if (vs == 0 && tw > w) tw = w;
		vh = (vs != 0) ? vs : ((th < h) ? th : h);
		check_window((w - tw) / 2, (w - tw) / 2 + tw - 1, (h - vh) / 2, (h - vh) / 2 + vh - 1);
	endtask

	function automatic int mix_expect(input int own, input int other);
		int v;
		v = (cur_mode == 2'd3) ? (own >>> 1) + (other >>> 1) : own;
		if (cur_att[4]) v = 0;
		else v = v >>> cur_att[3:0];
		if (v > 32767) v = 32767;
		else if (v < -32768) v = -32768;
		return v;
	endfunction

	function automatic sample_t rand_sample();
		return 16'($urandom());
	endfunction

	task automatic audio_case(input sample_t cl, input sample_t cr, input sample_t ll,
			input sample_t lr);
		int sum_l, sum_r;
		i_core_l  = cl;
		i_core_r  = cr;
		i_linux_l = ll;
		i_linux_r = lr;
		sum_l = int'(cl) + int'(ll);
		sum_r = int'(cr) + int'(lr);
		repeat (AUDIO_LATENCY) @(posedge clk);
		@(negedge clk);
		check_val("o_audio_l", int'(o_audio_l), mix_expect(sum_l, sum_r));
		check_val("o_audio_r", int'(o_audio_r), mix_expect(sum_r, sum_l));
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_val("o_io_ack", int'(o_io_ack), 0);
		check_val("o_audio_l", int'(o_audio_l), 0);
		check_val("o_audio_r", int'(o_audio_r), 0);
		check_window(0, 1919, 0, 1079);
		finish_test("reset defaults", e0);
	endtask

	task automatic test_video_mode();
		int e0;
		e0 = errors;
		cmd_words.delete();
		repeat (9) cmd_words.push_back(16'd0);
		cmd_words[`VMODE_WIDTH_IDX]  = 16'd640;
		cmd_words[`VMODE_HEIGHT_IDX] = 16'd480;
		send_command(`CMD_VIDEO_MODE);
		check_window(0, 639, 0, 479);
		finish_test("video mode command", e0);
	endtask

	task automatic test_aspect();
		int e0;
		e0 = errors;
		i_arx = 8'd16;
		i_ary = 8'd9;
		check_aspect(640, 480, 0, 16, 9);
		finish_test("aspect window", e0);
	endtask

	task automatic test_framebuffer();
		int e0;
		e0 = errors;
		// Cut short, the next command must start a fresh frame
		cmd_words.delete();
		cmd_words.push_back(16'd640);
		send_command(`CMD_VIDEO_MODE);
		cmd_words.delete();
		cmd_words.push_back(16'h8000);
		repeat (4) cmd_words.push_back(16'd0);
		cmd_words.push_back(16'd10);
		cmd_words.push_back(16'd100);
		cmd_words.push_back(16'd20);
		cmd_words.push_back(16'd200);
		send_command(`CMD_FB_WINDOW);
		check_window(10, 100, 20, 200);
		finish_test("framebuffer override", e0);
	endtask

	task automatic test_audio_mix();
		int e0;
		e0 = errors;
		cur_mode    = 2'd0;
		i_mix       = cur_mode;
		i_is_signed = 1'b1;
		repeat (4) audio_case(rand_sample(), rand_sample(), rand_sample(), rand_sample());
		// Left runs into the top limit, right into the bottom
		audio_case(16'sh7fff, 16'sh8000, 16'sh7fff, 16'sh8000);
		set_volume(5'd2);
		repeat (3) audio_case(rand_sample(), rand_sample(), rand_sample(), rand_sample());
		set_volume(5'h10);
		audio_case(rand_sample(), rand_sample(), rand_sample(), rand_sample());
		set_volume(5'd0);
		finish_test("audio mixing", e0);
	endtask

	task automatic test_stereo_blend();
		int e0;
		e0 = errors;
		cur_mode = 2'd3;
		i_mix    = cur_mode;
		repeat (4) audio_case(rand_sample(), rand_sample(), rand_sample(), rand_sample());
		audio_case(16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sh7fff);
		finish_test("stereo blend", e0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

	initial begin
		void'($urandom(32'hc857_249d));
		checks      = 0;
		errors      = 0;
		cur_mode    = 2'd0;
		cur_att     = 5'd0;
		i_io_en     = 1'b0;
		i_io_clk    = 1'b0;
		i_io_din    = 16'd0;
		i_mix       = 2'd0;
		i_is_signed = 1'b0;
		i_core_l    = 16'sd0;
		i_core_r    = 16'sd0;
		i_linux_l   = 16'sd0;
		i_linux_r   = 16'sd0;
		i_arx       = 8'd0;
		i_ary       = 8'd0;
		wait (resetd === 1'b0);
		@(negedge clk);
		test_reset();
		test_video_mode();
		test_aspect();
		test_framebuffer();
		test_audio_mix();
		test_stereo_blend();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset
// 20 ns clock, reset held high for the first 10 cycles

module tb_clk_gen (
	output logic clk,
	output logic resetd
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_NS      = 10;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

	// Release on a falling edge like every other input
	initial begin
		resetd = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		resetd = 1'b0;
	end

endmodule

//--- hps_cfg_properties.sv
// HPS configuration checks
// Host acknowledge timing and display window ordering,
// bound to the service block top level

module hps_cfg_properties (
	input logic                  clk,
	input logic                  resetd,
	input logic                  i_io_clk,
	input logic                  o_io_ack,
	input hps_cfg_pkg::pix_dim_t i_width,
	input hps_cfg_pkg::pix_dim_t i_height,
	input hps_cfg_pkg::pix_dim_t i_vset,
	input logic                  i_fb_en,
	input hps_cfg_pkg::pix_dim_t i_fb_hmin,
	input hps_cfg_pkg::pix_dim_t i_fb_hmax,
	input hps_cfg_pkg::pix_dim_t i_fb_vmin,
	input hps_cfg_pkg::pix_dim_t i_fb_vmax,
	input hps_cfg_pkg::aspect_t  i_arx,
	input hps_cfg_pkg::aspect_t  i_ary,
	input hps_cfg_pkg::pix_dim_t o_hmin,
	input hps_cfg_pkg::pix_dim_t o_hmax
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [100:0] cfg, cfg_q;
	logic [4:0]   stable_cnt;

	assign cfg = {i_width, i_height, i_vset, i_fb_en, i_fb_hmin, i_fb_hmax,
		i_fb_vmin, i_fb_vmax, i_arx, i_ary};

	// Cycles since the window inputs last changed, saturates at 20
	always_ff @(posedge clk) begin
		cfg_q <= cfg;
		if (resetd || cfg != cfg_q) begin
			stable_cnt <= 5'd0;
		end else if (stable_cnt != 5'd20) begin
			stable_cnt <= stable_cnt + 5'd1;
		end
	end

	ack_reset_low: assert property (@(posedge clk) resetd |=> !o_io_ack)
		else $error("host acknowledge high during reset");

	ack_two_late: assert property (@(posedge clk) disable iff (resetd)
		o_io_ack == $past(i_io_clk, 2))
		else $error("host acknowledge does not follow the strobe by two clocks");

	window_order: assert property (@(posedge clk) disable iff (resetd)
		(stable_cnt == 5'd20) |-> (o_hmin <= o_hmax))
		else $error("settled window has hmin above hmax");

endmodule

bind hps_cfg_top hps_cfg_properties u_props (
	.clk       (clk),
	.resetd    (resetd),
	.i_io_clk  (i_io_clk),
	.o_io_ack  (o_io_ack),
	.i_width   (width),
	.i_height  (height),
	.i_vset    (vset),
	.i_fb_en   (fb_en),
	.i_fb_hmin (fb_hmin),
	.i_fb_hmax (fb_hmax),
	.i_fb_vmin (fb_vmin),
	.i_fb_vmax (fb_vmax),
	.i_arx     (i_arx),
	.i_ary     (i_ary),
	.o_hmin    (o_hmin),
	.o_hmax    (o_hmax)
);

//--- hps_cfg_top.sv
// HPS configuration service block
// Host command decoder feeding the display window sequencer and the
// two cross-fed stereo mixer channels

module hps_cfg_top (
	input  logic                   clk,
	input  logic                   resetd,
	input  logic                   i_io_en,
	input  logic                   i_io_clk,
	input  hps_cfg_pkg::io_word_t  i_io_din,
	output logic                   o_io_ack,
	input  hps_cfg_pkg::mix_mode_t i_mix,
	input  logic                   i_is_signed,
	input  hps_cfg_pkg::sample_t   i_core_l,
	input  hps_cfg_pkg::sample_t   i_core_r,
	input  hps_cfg_pkg::sample_t   i_linux_l,
	input  hps_cfg_pkg::sample_t   i_linux_r,
	input  hps_cfg_pkg::aspect_t   i_arx,
	input  hps_cfg_pkg::aspect_t   i_ary,
	output hps_cfg_pkg::pix_dim_t  o_hmin,
	output hps_cfg_pkg::pix_dim_t  o_hmax,
	output hps_cfg_pkg::pix_dim_t  o_vmin,
	output hps_cfg_pkg::pix_dim_t  o_vmax,
	output hps_cfg_pkg::sample_t   o_audio_l,
	output hps_cfg_pkg::sample_t   o_audio_r
);
	import hps_cfg_pkg::*;

	pix_dim_t width, height, vset;
	logic     fb_en;
	pix_dim_t fb_hmin, fb_hmax, fb_vmin, fb_vmax;
	atten_t   vol_att;
	sample_t  pre_l, pre_r;

	host_cmd_ctrl u_ctrl (
		.clk       (clk),
		.resetd    (resetd),
		.i_io_en   (i_io_en),
		.i_io_clk  (i_io_clk),
		.i_io_din  (i_io_din),
		.o_io_ack  (o_io_ack),
		.o_width   (width),
		.o_height  (height),
		.o_vset    (vset),
		.o_fb_en   (fb_en),
		.o_fb_hmin (fb_hmin),
		.o_fb_hmax (fb_hmax),
		.o_fb_vmin (fb_vmin),
		.o_fb_vmax (fb_vmax),
		.o_vol_att (vol_att)
	);

	video_window_calc u_window (
		.clk       (clk),
		.resetd    (resetd),
		.i_width   (width),
		.i_height  (height),
		.i_vset    (vset),
		.i_fb_en   (fb_en),
		.i_fb_hmin (fb_hmin),
		.i_fb_hmax (fb_hmax),
		.i_fb_vmin (fb_vmin),
		.i_fb_vmax (fb_vmax),
		.i_arx     (i_arx),
		.i_ary     (i_ary),
		.o_hmin    (o_hmin),
		.o_hmax    (o_hmax),
		.o_vmin    (o_vmin),
		.o_vmax    (o_vmax)
	);

	////////////////////////////////////////
	// Stereo pair, each feeds the other
	////////////////////////////////////////

	audio_mix_chan u_mix_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_att       (vol_att),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_core      (i_core_l),
		.i_linux     (i_linux_l),
		.i_pre       (pre_r),
		.o_pre       (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mix_chan u_mix_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_att       (vol_att),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_core      (i_core_r),
		.i_linux     (i_linux_r),
		.i_pre       (pre_l),
		.o_pre       (pre_r),
		.o_out       (o_audio_r)
	);

endmodule

//--- audio_mix_chan.sv
// Audio mixer channel
// Stabilizes the core sample, adds the host sample, blends in the
// opposite channel for stereo narrowing, attenuates and clamps to
// 16 bits. Eight clocks from core input to output

module audio_mix_chan (
	input  logic                   clk,
	input  logic                   resetd,
	input  hps_cfg_pkg::atten_t    i_att,
	input  hps_cfg_pkg::mix_mode_t i_mix,
	input  logic                   i_is_signed,
	input  hps_cfg_pkg::sample_t   i_core,
	input  hps_cfg_pkg::sample_t   i_linux,
	input  hps_cfg_pkg::sample_t   i_pre,
	output hps_cfg_pkg::sample_t   o_pre,
	output hps_cfg_pkg::sample_t   o_out
);
	import hps_cfg_pkg::*;

	sample_t  core_d1, core_d2, core_q;
	mix_sum_t a1, a2, a3, a4;
	mix_sum_t pre_w;

	// Other channel's half sum, sign extended
	assign pre_w = mix_sum_t'(i_pre);
	assign o_pre = a2[16:1];

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1 <= '0;
			core_d2 <= '0;
			core_q  <= '0;
			a1      <= '0;
			a2      <= '0;
			a3      <= '0;
			a4      <= '0;
			o_out   <= '0;
		end else begin
			// Core sample must hold for two cycles before it is taken
			core_d1 <= i_core;
			core_d2 <= core_d1;
			if (core_d1 == core_d2) core_q <= core_d1;

			// Unsigned core audio is halved to stay in range
			a1 <= i_is_signed ? mix_sum_t'(core_q) : mix_sum_t'({2'b00, core_q[15:1]});
			a2 <= a1 + mix_sum_t'(i_linux);

			case (i_mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + (pre_w >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + (pre_w >>> 1);
				default: a3 <= (a2 >>> 1) + pre_w;
			endcase

			if (i_att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[3:0];
			end

			// Saturate when bits 16 and 15 disagree
			o_out <= (a4[16] ^ a4[15]) ? {a4[16], {15{a4[15]}}} : a4[15:0];
		end
	end

endmodule

//--- video_window_calc.sv
// Display window sequencer
// Derives the visible window (min/max pixel per axis) from the active
// video mode, the vertical override and the core aspect ratio, or takes
// the framebuffer window when the framebuffer is enabled

`include "hps_cfg_consts.svh"

module video_window_calc (
	input  logic                  clk,
	input  logic                  resetd,
	input  hps_cfg_pkg::pix_dim_t i_width,
	input  hps_cfg_pkg::pix_dim_t i_height,
	input  hps_cfg_pkg::pix_dim_t i_vset,
	input  logic                  i_fb_en,
	input  hps_cfg_pkg::pix_dim_t i_fb_hmin,
	input  hps_cfg_pkg::pix_dim_t i_fb_hmax,
	input  hps_cfg_pkg::pix_dim_t i_fb_vmin,
	input  hps_cfg_pkg::pix_dim_t i_fb_vmax,
	input  hps_cfg_pkg::aspect_t  i_arx,
	input  hps_cfg_pkg::aspect_t  i_ary,
	output hps_cfg_pkg::pix_dim_t o_hmin,
	output hps_cfg_pkg::pix_dim_t o_hmax,
	output hps_cfg_pkg::pix_dim_t o_vmin,
	output hps_cfg_pkg::pix_dim_t o_vmax
);
	import hps_cfg_pkg::*;

	win_phase_t  phase;
	logic [2:0]  step;
	aspect_t     ar_x, ar_y;
	logic [19:0] num_w, num_h;
	logic [19:0] quo_w, quo_h;
	pix_dim_t    vid_w, vid_h;
	pix_dim_t    base_h;
	pix_dim_t    gap_w, gap_h;

	// Vertical override replaces the height as width reference
	assign base_h = (i_vset != 12'd0) ? i_vset : i_height;
	assign gap_w  = i_width - vid_w;
	assign gap_h  = i_height - vid_h;

	// Select, five divide steps, clip, place
	always_ff @(posedge clk) begin
		if (resetd) begin
			phase  <= WP_SELECT;
			step   <= 3'd0;
			o_hmin <= 12'd0;
			o_hmax <= `DEF_WIDTH - 12'd1;
			o_vmin <= 12'd0;
			o_vmax <= `DEF_HEIGHT - 12'd1;
		end else begin
			step <= step + 3'd1;
			case (phase)
				WP_SELECT: begin
					if (i_fb_en) begin
						o_hmin <= i_fb_hmin;
						o_hmax <= i_fb_hmax;
						o_vmin <= i_fb_vmin;
						o_vmax <= i_fb_vmax;
						step   <= 3'd0;
					end else if (i_arx != 8'd0 && i_ary != 8'd0) begin
						phase <= WP_DIVIDE;
					end else begin
						// No aspect given, show the whole frame
						o_hmin <= 12'd0;
						o_hmax <= i_width - 12'd1;
						o_vmin <= 12'd0;
						o_vmax <= i_height - 12'd1;
						step   <= 3'd0;
					end
				end
				WP_DIVIDE: begin
					if (step == 3'd5) phase <= WP_CLIP;
				end
				WP_CLIP: begin
					phase <= WP_PLACE;
				end
				default: begin
					phase <= WP_SELECT;
				end
			endcase
			if (phase == WP_PLACE) begin
				o_hmin <= gap_w >> 1;
				o_hmax <= (gap_w >> 1) + vid_w - 12'd1;
				o_vmin <= gap_h >> 1;
				o_vmax <= (gap_h >> 1) + vid_h - 12'd1;
			end
		end
	end

	// Datapath, divider has the whole divide phase to settle
	always_ff @(posedge clk) begin
		if (phase == WP_SELECT) begin
			ar_x  <= i_arx;
			ar_y  <= i_ary;
			num_w <= 20'(base_h) * 20'(i_arx);
			num_h <= 20'(i_width) * 20'(i_ary);
		end
		if (phase == WP_DIVIDE) begin
			quo_w <= num_w / 20'(ar_y);
			quo_h <= num_h / 20'(ar_x);
		end
		if (phase == WP_CLIP) begin
			vid_w <= (i_vset == 12'd0 && quo_w > 20'(i_width)) ? i_width : quo_w[11:0];
			if (i_vset != 12'd0) begin
				vid_h <= i_vset;
			end else begin
				vid_h <= (quo_h > 20'(i_height)) ? i_height : quo_h[11:0];
			end
		end
	end

endmodule

//--- host_cmd_ctrl.sv
// Host command decoder
// Receives 16-bit words over the toggle/acknowledge host port, frames
// them into a command followed by numbered data words and keeps the
// video mode, framebuffer window, vertical override and volume registers

`include "hps_cfg_consts.svh"

module host_cmd_ctrl (
	input  logic                  clk,
	input  logic                  resetd,
	input  logic                  i_io_en,
	input  logic                  i_io_clk,
	input  hps_cfg_pkg::io_word_t i_io_din,
	output logic                  o_io_ack,
	output hps_cfg_pkg::pix_dim_t o_width,
	output hps_cfg_pkg::pix_dim_t o_height,
	output hps_cfg_pkg::pix_dim_t o_vset,
	output logic                  o_fb_en,
	output hps_cfg_pkg::pix_dim_t o_fb_hmin,
	output hps_cfg_pkg::pix_dim_t o_fb_hmax,
	output hps_cfg_pkg::pix_dim_t o_fb_vmin,
	output hps_cfg_pkg::pix_dim_t o_fb_vmax,
	output hps_cfg_pkg::atten_t   o_vol_att
);
	import hps_cfg_pkg::*;

	logic       io_clk_s1;
	logic       en_q;
	logic       word_q;
	io_word_t   din_q;
	cmd_state_t state;
	cmd_code_t  cmd;
	logic [3:0] cnt;
	logic       take_cmd;
	logic       take_data;
	logic       wr_stb;
	cmd_code_t  wr_cmd;
	logic [3:0] wr_idx;
	io_word_t   wr_data;

	////////////////////////////////////////
	// Host strobe and acknowledge
	////////////////////////////////////////

	// Ack is the host strobe two registers late
	always_ff @(posedge clk) begin
		if (resetd) begin
			io_clk_s1 <= 1'b0;
			o_io_ack  <= 1'b0;
			en_q      <= 1'b0;
			word_q    <= 1'b0;
		end else begin
			io_clk_s1 <= i_io_clk;
			o_io_ack  <= io_clk_s1;
			en_q      <= i_io_en;
			word_q    <= io_clk_s1 & ~o_io_ack;
		end
	end

	// Host keeps the word stable until it sees the ack
	always_ff @(posedge clk) begin
		din_q <= i_io_din;
	end

	////////////////////////////////////////
	// Command framing
	////////////////////////////////////////

	assign take_cmd  = en_q & word_q & (state == CS_IDLE);
	assign take_data = en_q & word_q & (state == CS_DATA) & (cnt != `CMD_WORD_END);

	always_ff @(posedge clk) begin
		if (resetd) begin
			state  <= CS_IDLE;
			cnt    <= 4'd0;
			wr_stb <= 1'b0;
		end else begin
			wr_stb <= take_data;
			if (!en_q) begin
				state <= CS_IDLE;
			end else if (take_cmd) begin
				state <= CS_DATA;
				cnt   <= 4'd0;
			end else if (take_data) begin
				cnt <= cnt + 4'd1;
			end
		end
	end

	// Command code and the pending register write
	always_ff @(posedge clk) begin
		if (take_cmd) begin
			cmd <= din_q[7:0];
		end
		if (take_data) begin
			wr_cmd  <= cmd;
			wr_idx  <= cnt;
			wr_data <= din_q;
		end
	end

	////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_width   <= `DEF_WIDTH;
			o_height  <= `DEF_HEIGHT;
			o_vset    <= 12'd0;
			o_fb_en   <= 1'b0;
			o_fb_hmin <= 12'd0;
			o_fb_hmax <= 12'd0;
			o_fb_vmin <= 12'd0;
			o_fb_vmax <= 12'd0;
			o_vol_att <= 5'd0;
		end else if (wr_stb) begin
			case (wr_cmd)
				`CMD_VIDEO_MODE: begin
					// Porch and sync words are counted but not kept
					if (wr_idx == `VMODE_WIDTH_IDX) o_width <= wr_data[11:0];
					if (wr_idx == `VMODE_HEIGHT_IDX) o_height <= wr_data[11:0];
				end
				`CMD_FB_WINDOW: begin
					case (wr_idx)
						4'd0:                 o_fb_en   <= wr_data[15];
						`FBW_HMIN_IDX:        o_fb_hmin <= wr_data[11:0];
						`FBW_HMIN_IDX + 4'd1: o_fb_hmax <= wr_data[11:0];
						`FBW_HMIN_IDX + 4'd2: o_fb_vmin <= wr_data[11:0];
						`FBW_HMIN_IDX + 4'd3: o_fb_vmax <= wr_data[11:0];
						default: ;
					endcase
				end
				`CMD_VOLUME: begin
					if (wr_idx == 4'd0) o_vol_att <= wr_data[4:0];
				end
				`CMD_VSET: begin
					if (wr_idx == 4'd0) o_vset <= wr_data[11:0];
				end
				default: ;
			endcase
		end
	end

endmodule

//--- hps_cfg_pkg.sv
// HPS configuration types
// Vector types for host words, pixel dimensions and audio samples,
// plus the state encodings of the command decoder and window sequencer

package hps_cfg_pkg;

	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  cmd_code_t;
	typedef logic [11:0] pix_dim_t;
	typedef logic [7:0]  aspect_t;

	// Audio samples and the mixer's internal headroom
	typedef logic signed [15:0] sample_t;
	typedef logic signed [16:0] mix_sum_t;

	// Bit 4 mutes, bits 3:0 are the right shift
	typedef logic [4:0] atten_t;
	typedef logic [1:0] mix_mode_t;

	typedef enum logic {
		CS_IDLE,
		CS_DATA
	} cmd_state_t;

	typedef enum logic [1:0] {
		WP_SELECT,
		WP_DIVIDE,
		WP_CLIP,
		WP_PLACE
	} win_phase_t;

endpackage

//--- hps_cfg_consts.svh
// HPS configuration constants
// Host command codes, reset video mode and the data word
// positions used when framing host commands

`ifndef HPS_CFG_CONSTS_SVH
`define HPS_CFG_CONSTS_SVH

// Host command codes (low byte of the command word)
`define CMD_VIDEO_MODE    8'h20
`define CMD_VOLUME        8'h26
`define CMD_VSET          8'h27
`define CMD_FB_WINDOW     8'h2F

// Reset video mode, 1080p
`define DEF_WIDTH         12'd1920
`define DEF_HEIGHT        12'd1080

// Data word positions inside a command
`define VMODE_WIDTH_IDX   4'd0
`define VMODE_HEIGHT_IDX  4'd4
`define FBW_HMIN_IDX      4'd5

// Data counter parks here once word 8 has been taken
`define CMD_WORD_END      4'd9

`endif
